// File: Bender.yml
package:
  name: div_unit

sources:
  - target: any(rtl, test)
    files:
      - common/div_pkg.sv
      - rtl/div_operand_prep.sv
      - rtl/div_core/div_core.sv
      - rtl/div_result_fix.sv
      - rtl/div_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/div_tb.sv

// File: common/div_pkg.sv
`default_nettype none

package div_pkg;

    // operand and result width
    localparam int XLEN = 64;

    // active width of the word-mode ops
    localparam int WORD_W = 32;

    // step counter, counts 0..XLEN-1
    localparam int STEP_W = 7;

    typedef logic [XLEN-1:0] xlen_t;

    typedef enum logic [1:0] {
        DIV_OP_DIV   = 2'b00,
        DIV_OP_DIVU  = 2'b01,
        DIV_OP_DIVW  = 2'b10,
        DIV_OP_DIVUW = 2'b11
    } div_op_e;

    // free -> on for XLEN steps -> end until the result is taken
    typedef enum logic [1:0] {
        DIV_FREE = 2'd0,
        DIV_ON   = 2'd1,
        DIV_END  = 2'd2
    } div_state_e;

endpackage

`default_nettype wire

// File: div_unit.f
+incdir+test
common/div_pkg.sv
rtl/div_operand_prep.sv
rtl/div_core/div_core.sv
rtl/div_result_fix.sv
rtl/div_top.sv
test/div_tb.sv

// File: rtl/div_core/div_core.sv
`timescale 1ns/100ps
`default_nettype none

module div_core (
    input  wire logic           clk,
    input  wire logic           rst_n,

    input  wire logic           in_valid,
    output logic                in_ready,
    input  wire div_pkg::xlen_t dividend_mag,
    input  wire div_pkg::xlen_t divisor_mag,
    input  wire logic           neg_quot_in,
    input  wire logic           neg_rem_in,
    input  wire logic           word_mode_in,

    output logic                out_valid,
    input  wire logic           out_ready,
    output div_pkg::xlen_t      quot_mag,
    output div_pkg::xlen_t      rem_mag,
    output logic                neg_quot,
    output logic                neg_rem,
    output logic                word_mode
);
    import div_pkg::*;

    div_state_e        state;
    logic [STEP_W-1:0] step;
    xlen_t             divisor_q;

    logic              accept;
    logic              last_step;
    logic [XLEN:0]     part_rem;
    logic [XLEN:0]     trial;
    logic              borrow;

    assign in_ready  = (state == DIV_FREE);
    assign out_valid = (state == DIV_END);
    assign accept    = in_valid && in_ready;
    assign last_step = (step == STEP_W'(XLEN - 1));

    // bring down the next dividend bit, which is the msb of quot_mag
    assign part_rem = {rem_mag, quot_mag[XLEN-1]};
    assign trial    = part_rem - {1'b0, divisor_q};
    assign borrow   = trial[XLEN];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= DIV_FREE;
            step  <= '0;
        end else begin
            unique case (state)
                DIV_FREE: begin
                    if (accept) begin
                        state <= DIV_ON;
                        step  <= '0;
                    end
                end
                DIV_ON: begin
                    step <= step + 1'b1;
                    if (last_step) begin
                        state <= DIV_END;
                    end
                end
                DIV_END: begin
                    // hold results until the sink takes them
                    if (out_ready) begin
                        state <= DIV_FREE;
                    end
                end
                default: begin
                    state <= DIV_FREE;
                end
            endcase
        end
    end

    // quot_mag starts out holding the dividend; each step shifts one
    // dividend bit out at the top and one quotient bit in at the bottom
    always_ff @(posedge clk) begin
        if (accept) begin
            divisor_q <= divisor_mag;
            quot_mag  <= dividend_mag;
            rem_mag   <= '0;
            neg_quot  <= neg_quot_in;
            neg_rem   <= neg_rem_in;
            word_mode <= word_mode_in;
        end else if (state == DIV_ON) begin
            quot_mag <= {quot_mag[XLEN-2:0], ~borrow};
            // restore on borrow
            rem_mag  <= borrow ? part_rem[XLEN-1:0] : trial[XLEN-1:0];
        end
    end

    // result shows up exactly XLEN cycles after the accept edge
    assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> !out_valid [*XLEN] ##1 out_valid)
        else $error("div_core: result latency is not XLEN cycles");

    // stalled result stays put until the handoff
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=>
            out_valid && $stable(quot_mag) && $stable(rem_mag))
        else $error("div_core: result changed under back-pressure");

    // upper halves of word-mode magnitudes are zero
    assert property (@(posedge clk) disable iff (!rst_n)
        accept && word_mode_in |->
            dividend_mag[XLEN-1:WORD_W] == '0 && divisor_mag[XLEN-1:WORD_W] == '0)
        else $error("div_core: word-mode operand has a nonzero upper half");

endmodule

`default_nettype wire

// File: rtl/div_operand_prep.sv
`timescale 1ns/100ps
`default_nettype none

module div_operand_prep (
    input  wire div_pkg::div_op_e op,
    input  wire div_pkg::xlen_t   dividend,
    input  wire div_pkg::xlen_t   divisor,
    output div_pkg::xlen_t        dividend_mag,
    output div_pkg::xlen_t        divisor_mag,
    output logic                  neg_quot,
    output logic                  neg_rem,
    output logic                  word_mode
);
    import div_pkg::*;

    logic is_signed;
    logic dividend_neg;
    logic divisor_neg;

    // absolute value over the active width, zero-extended in word mode
    function automatic xlen_t magnitude(
        input xlen_t value,
        input logic  neg,
        input logic  word
    );
        logic [WORD_W-1:0] low;
        xlen_t             full;
        low  = neg ? (~value[WORD_W-1:0] + 1'b1) : value[WORD_W-1:0];
        full = neg ? (~value + 1'b1) : value;
        return word ? {{(XLEN-WORD_W){1'b0}}, low} : full;
    endfunction

    assign word_mode = (op == DIV_OP_DIVW) || (op == DIV_OP_DIVUW);
    assign is_signed = (op == DIV_OP_DIV) || (op == DIV_OP_DIVW);

    // sign bit sits at the top of the active width
    assign dividend_neg = is_signed &
                          (word_mode ? dividend[WORD_W-1] : dividend[XLEN-1]);
    assign divisor_neg  = is_signed &
                          (word_mode ? divisor[WORD_W-1] : divisor[XLEN-1]);

    assign dividend_mag = magnitude(dividend, dividend_neg, word_mode);
    assign divisor_mag  = magnitude(divisor, divisor_neg, word_mode);

    // remainder follows the dividend, quotient negative on mixed signs
    assign neg_rem  = dividend_neg;
    assign neg_quot = dividend_neg ^ divisor_neg;

endmodule

`default_nettype wire

// File: rtl/div_result_fix.sv
`timescale 1ns/100ps
`default_nettype none

module div_result_fix (
    input  wire div_pkg::xlen_t quot_mag,
    input  wire div_pkg::xlen_t rem_mag,
    input  wire logic           neg_quot,
    input  wire logic           neg_rem,
    input  wire logic           word_mode,
    output div_pkg::xlen_t      quotient,
    output div_pkg::xlen_t      remainder
);
    import div_pkg::*;

    // negate on request; word results are 32-bit values sign-extended
    function automatic xlen_t apply_sign(
        input xlen_t mag,
        input logic  neg,
        input logic  word
    );
        logic [WORD_W-1:0] low;
        xlen_t             full;
        low  = neg ? (~mag[WORD_W-1:0] + 1'b1) : mag[WORD_W-1:0];
        full = neg ? (~mag + 1'b1) : mag;
        return word ? {{(XLEN-WORD_W){low[WORD_W-1]}}, low} : full;
    endfunction

    // most negative / -1 comes out as the most negative value here,
    // since its magnitude negates to itself
    assign quotient  = apply_sign(quot_mag, neg_quot, word_mode);
    assign remainder = apply_sign(rem_mag, neg_rem, word_mode);

endmodule

`default_nettype wire

// File: rtl/div_top.sv
`timescale 1ns/100ps
`default_nettype none

module div_top (
    input  wire logic             clk,
    input  wire logic             rst_n,

    input  wire logic             in_valid,
    output logic                  in_ready,
    input  wire div_pkg::div_op_e op,
    input  wire div_pkg::xlen_t   dividend,
    input  wire div_pkg::xlen_t   divisor,

    output logic                  out_valid,
    input  wire logic             out_ready,
    output div_pkg::xlen_t        quotient,
    output div_pkg::xlen_t        remainder
);
    import div_pkg::*;

    // operand side, combinational from the inputs
    xlen_t dividend_mag;
    xlen_t divisor_mag;
    logic  prep_neg_quot;
    logic  prep_neg_rem;
    logic  prep_word_mode;

    // result side, held by the core
    xlen_t quot_mag;
    xlen_t rem_mag;
    logic  core_neg_quot;
    logic  core_neg_rem;
    logic  core_word_mode;

    div_operand_prep prep_i (
        .op           (op),
        .dividend     (dividend),
        .divisor      (divisor),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag),
        .neg_quot     (prep_neg_quot),
        .neg_rem      (prep_neg_rem),
        .word_mode    (prep_word_mode)
    );

    div_core core_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag),
        .neg_quot_in  (prep_neg_quot),
        .neg_rem_in   (prep_neg_rem),
        .word_mode_in (prep_word_mode),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .quot_mag     (quot_mag),
        .rem_mag      (rem_mag),
        .neg_quot     (core_neg_quot),
        .neg_rem      (core_neg_rem),
        .word_mode    (core_word_mode)
    );

    div_result_fix fix_i (
        .quot_mag  (quot_mag),
        .rem_mag   (rem_mag),
        .neg_quot  (core_neg_quot),
        .neg_rem   (core_neg_rem),
        .word_mode (core_word_mode),
        .quotient  (quotient),
        .remainder (remainder)
    );

endmodule

`default_nettype wire

// File: test/div_vectors.svh
`ifndef DIV_VECTORS_SVH
`define DIV_VECTORS_SVH

// one row per call: name, opcode, dividend, divisor,
// then expected quotient and expected remainder
task automatic load_vectors();
    add_vector("divu_basic", DIV_OP_DIVU,
               64'd100, 64'd7,
               64'd14, 64'd2);
    add_vector("divu_divisor_larger", DIV_OP_DIVU,
               64'd5, 64'd9,
               64'd0, 64'd5);
    add_vector("divu_all_ones", DIV_OP_DIVU,
               64'hffff_ffff_ffff_ffff, 64'd2,
               64'h7fff_ffff_ffff_ffff, 64'd1);
    add_vector("divu_wide", DIV_OP_DIVU,
               64'h1234_5678_9abc_def0, 64'h0000_0000_0001_0000,
               64'h0000_1234_5678_9abc, 64'h0000_0000_0000_def0);
    add_vector("divu_top_bit", DIV_OP_DIVU,
               64'h8000_0000_0000_0000, 64'd3,
               64'h2aaa_aaaa_aaaa_aaaa, 64'd2);
    // signed, all four sign combinations
    add_vector("div_pos_pos", DIV_OP_DIV,
               64'd100, 64'd7,
               64'd14, 64'd2);
    add_vector("div_neg_pos", DIV_OP_DIV,
               64'hffff_ffff_ffff_ff9c, 64'd7,
               64'hffff_ffff_ffff_fff2, 64'hffff_ffff_ffff_fffe);
    add_vector("div_pos_neg", DIV_OP_DIV,
               64'd100, 64'hffff_ffff_ffff_fff9,
               64'hffff_ffff_ffff_fff2, 64'd2);
    add_vector("div_neg_neg", DIV_OP_DIV,
               64'hffff_ffff_ffff_ff9c, 64'hffff_ffff_ffff_fff9,
               64'd14, 64'hffff_ffff_ffff_fffe);
    add_vector("div_overflow", DIV_OP_DIV,
               64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff,
               64'h8000_0000_0000_0000, 64'd0);
    add_vector("div_small_neg", DIV_OP_DIV,
               64'hffff_ffff_ffff_fffd, 64'd5,
               64'd0, 64'hffff_ffff_ffff_fffd);
    // word mode, upper halves are junk
    add_vector("divw_basic", DIV_OP_DIVW,
               64'hdead_beef_0000_0064, 64'h1234_5678_0000_0007,
               64'd14, 64'd2);
    add_vector("divw_neg", DIV_OP_DIVW,
               64'h0000_0001_ffff_ff9c, 64'h7777_7777_0000_0007,
               64'hffff_ffff_ffff_fff2, 64'hffff_ffff_ffff_fffe);
    add_vector("divw_overflow", DIV_OP_DIVW,
               64'h0123_4567_8000_0000, 64'h0000_0000_ffff_ffff,
               64'hffff_ffff_8000_0000, 64'd0);
    add_vector("divuw_basic", DIV_OP_DIVUW,
               64'hffff_ffff_0000_0064, 64'h0000_0001_0000_0007,
               64'd14, 64'd2);
    add_vector("divuw_bit31_quot", DIV_OP_DIVUW,
               64'h5555_5555_ffff_fffe, 64'haaaa_aaaa_0000_0001,
               64'hffff_ffff_ffff_fffe, 64'd0);
    add_vector("divuw_rem", DIV_OP_DIVUW,
               64'h0000_0000_ffff_ffff, 64'h0000_0000_8000_0001,
               64'd1, 64'h0000_0000_7fff_fffe);
endtask

`endif

// File: test/div_tb.sv
`timescale 1ns/100ps
`default_nettype none

module div_tb;
    import div_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 10;
    localparam int RESET_CYCLES = 4;
    localparam int WAIT_LIMIT   = 200;
    localparam int RANDOM_COUNT = 40;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    logic    in_ready;
    div_op_e op;
    xlen_t   dividend;
    xlen_t   divisor;
    logic    out_valid;
    logic    out_ready;
    xlen_t   quotient;
    xlen_t   remainder;

    logic [31:0] rand_state;
    int          num_checks;
    int          mismatch_errors;
    int          timeout_errors;

    // directed table
    string   vec_name[$];
    div_op_e vec_op[$];
    xlen_t   vec_a[$];
    xlen_t   vec_b[$];
    xlen_t   vec_q[$];
    xlen_t   vec_r[$];

    div_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op        (op),
        .dividend  (dividend),
        .divisor   (divisor),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .quotient  (quotient),
        .remainder (remainder)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic add_vector(input string name, input div_op_e op_v, input xlen_t a,
                              input xlen_t b, input xlen_t q, input xlen_t r);
        vec_name.push_back(name);
        vec_op.push_back(op_v);
        vec_a.push_back(a);
        vec_b.push_back(b);
        vec_q.push_back(q);
        vec_r.push_back(r);
    endtask

    `include "div_vectors.svh"

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic check_xlen(input string name, input string field,
                              input xlen_t expected, input xlen_t actual);
        num_checks++;
        if (actual !== expected) begin
            mismatch_errors++;
            $display("MISMATCH %s %s: expected %h, actual %h", name, field, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input string field,
                              input logic expected, input logic actual);
        num_checks++;
        if (actual !== expected) begin
            mismatch_errors++;
            $display("MISMATCH %s %s: expected %b, actual %b", name, field, expected, actual);
        end
    endtask

    task automatic check_int(input string name, input string field,
                             input int expected, input int actual);
        num_checks++;
        if (actual != expected) begin
            mismatch_errors++;
            $display("MISMATCH %s %s: expected %0d, actual %0d", name, field, expected, actual);
        end
    endtask

    // truncating division, remainder follows the dividend
    task automatic ref_divide(input div_op_e op_v, input xlen_t a, input xlen_t b,
                              output xlen_t q, output xlen_t r);
        logic signed [XLEN-1:0]   sa;
        logic signed [XLEN-1:0]   sb;
        logic signed [WORD_W-1:0] wa;
        logic signed [WORD_W-1:0] wb;
        logic [WORD_W-1:0]        wq;
        logic [WORD_W-1:0]        wr;
        sa = a;
        sb = b;
        wa = a[WORD_W-1:0];
        wb = b[WORD_W-1:0];
        wq = '0;
        wr = '0;
        q  = '0;
        r  = '0;
        case (op_v)
            DIV_OP_DIVU: begin
                q = a / b;
                r = a % b;
            end
            DIV_OP_DIV: begin
                // overflow wraps to the most negative value
                if (a == {1'b1, {(XLEN-1){1'b0}}} && b == '1) begin
                    q = a;
                end else begin
                    q = sa / sb;
                    r = sa % sb;
                end
            end
            DIV_OP_DIVW: begin
                if (wa == {1'b1, {(WORD_W-1){1'b0}}} && wb == '1) begin
                    wq = wa;
                end else begin
                    wq = wa / wb;
                    wr = wa % wb;
                end
            end
            default: begin
                wq = a[WORD_W-1:0] / b[WORD_W-1:0];
                wr = a[WORD_W-1:0] % b[WORD_W-1:0];
            end
        endcase
        if (op_v == DIV_OP_DIVW || op_v == DIV_OP_DIVUW) begin
            q = {{(XLEN-WORD_W){wq[WORD_W-1]}}, wq};
            r = {{(XLEN-WORD_W){wr[WORD_W-1]}}, wr};
        end
    endtask

    // entered just after an edge; returns just after the accept edge
    task automatic send_op(input string name, input div_op_e op_v,
                           input xlen_t a, input xlen_t b);
        int cycles;
        in_valid = 1'b1;
        op       = op_v;
        dividend = a;
        divisor  = b;
        cycles   = 0;
        while (!in_ready) begin
            if (cycles >= WAIT_LIMIT) begin
                $display("ERROR: %s: in_ready stayed low for %0d cycles", name, cycles);
                timeout_errors++;
                return;
            end
            @(posedge clk);
            #DRIVE_DLY;
            cycles++;
        end
        @(posedge clk);
        #DRIVE_DLY;
        in_valid = 1'b0;
    endtask

    task automatic wait_valid(input string name, output int cycles);
        logic [31:0] rnd;
        cycles = 0;
        while (!out_valid) begin
            if (cycles >= WAIT_LIMIT) begin
                $display("ERROR: %s: out_valid did not rise within %0d cycles", name, cycles);
                timeout_errors++;
                return;
            end
            // out_ready means nothing before the result, so wiggle it
            rnd       = next_rand();
            out_ready = rnd[31];
            @(posedge clk);
            #DRIVE_DLY;
            cycles++;
        end
    endtask

    // hold off the sink for stall cycles, then take the result
    task automatic take_result(input string name, input xlen_t exp_q, input xlen_t exp_r,
                               input int stall);
        for (int i = 0; i < stall; i++) begin
            out_ready = 1'b0;
            check_xlen(name, "quotient", exp_q, quotient);
            check_xlen(name, "remainder", exp_r, remainder);
            check_flag(name, "in_ready", 1'b0, in_ready);
            @(posedge clk);
            #DRIVE_DLY;
            check_flag(name, "out_valid", 1'b1, out_valid);
        end
        out_ready = 1'b1;
        check_xlen(name, "quotient", exp_q, quotient);
        check_xlen(name, "remainder", exp_r, remainder);
        @(posedge clk);
        #DRIVE_DLY;
        out_ready = 1'b0;
        check_flag(name, "out_valid", 1'b0, out_valid);
        check_flag(name, "in_ready", 1'b1, in_ready);
    endtask

    task automatic run_vector(input string name, input div_op_e op_v, input xlen_t a,
                              input xlen_t b, input xlen_t q, input xlen_t r, input int stall);
        int cycles;
        send_op(name, op_v, a, b);
        if (timeout_errors != 0) return;
        wait_valid(name, cycles);
        if (timeout_errors != 0) return;
        check_int(name, "latency", XLEN, cycles);
        take_result(name, q, r, stall);
    endtask

    // second op waits at the input while the first result is stalled
    task automatic run_backpressure();
        xlen_t q_a;
        xlen_t r_a;
        xlen_t q_b;
        xlen_t r_b;
        int    cycles;
        ref_divide(DIV_OP_DIVU, 64'd1000, 64'd33, q_a, r_a);
        ref_divide(DIV_OP_DIV, 64'hffff_ffff_ffff_fff7, 64'd4, q_b, r_b);
        send_op("bp_first", DIV_OP_DIVU, 64'd1000, 64'd33);
        if (timeout_errors != 0) return;
        wait_valid("bp_first", cycles);
        if (timeout_errors != 0) return;
        out_ready = 1'b0;
        in_valid  = 1'b1;
        op        = DIV_OP_DIV;
        dividend  = 64'hffff_ffff_ffff_fff7;
        divisor   = 64'd4;
        take_result("bp_first", q_a, r_a, 6);
        @(posedge clk);
        #DRIVE_DLY;
        in_valid = 1'b0;
        wait_valid("bp_second", cycles);
        if (timeout_errors != 0) return;
        check_int("bp_second", "latency", XLEN, cycles);
        take_result("bp_second", q_b, r_b, 0);
    endtask

    task automatic run_random(input int count);
        logic [31:0] ctl;
        div_op_e     op_v;
        xlen_t       a;
        xlen_t       b;
        xlen_t       q;
        xlen_t       r;
        for (int i = 0; i < count; i++) begin
            ctl  = next_rand();
            op_v = div_op_e'(ctl[31:30]);
            a    = {next_rand(), next_rand()};
            b    = {next_rand(), next_rand()};
            b    = b >> ctl[29:24];
            // no zero divisor over the active width
            if (op_v == DIV_OP_DIVW || op_v == DIV_OP_DIVUW) begin
                if (b[WORD_W-1:0] == '0) b[0] = 1'b1;
            end else if (b == '0) begin
                b[0] = 1'b1;
            end
            ref_divide(op_v, a, b, q, r);
            run_vector($sformatf("rand_%0d", i), op_v, a, b, q, r, int'(ctl[21:20]));
            if (timeout_errors != 0) break;
        end
    endtask

    initial begin
        rst_n           = 1'b0;
        in_valid        = 1'b0;
        op              = DIV_OP_DIV;
        dividend        = '0;
        divisor         = '0;
        out_ready       = 1'b0;
        rand_state      = 32'hdff5;
        num_checks      = 0;
        mismatch_errors = 0;
        timeout_errors  = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        check_flag("reset", "in_ready", 1'b1, in_ready);
        check_flag("reset", "out_valid", 1'b0, out_valid);

        load_vectors();
        for (int i = 0; i < vec_name.size(); i++) begin
            run_vector(vec_name[i], vec_op[i], vec_a[i], vec_b[i], vec_q[i], vec_r[i], i % 3);
            if (timeout_errors != 0) break;
        end
        if (timeout_errors == 0) run_backpressure();
        if (timeout_errors == 0) run_random(RANDOM_COUNT);

        $display("checks %0d, mismatches %0d, timeouts %0d",
                 num_checks, mismatch_errors, timeout_errors);
        if (mismatch_errors == 0 && timeout_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
